// ==== cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl #(
    parameter int INDEX_W = 14
) (
    input  logic                 clk,
    input  logic                 rst,
    input  cache_pkg::p_addr_t   i_p_addr,
    input  cache_pkg::byte_en_t  i_p_byte_en,
    input  cache_pkg::word_t     i_p_writedata,
    input  logic                 i_p_read,
    input  logic                 i_p_write,
    output cache_pkg::word_t     o_p_readdata,
    output logic                 o_p_readdata_valid,
    output logic                 o_p_waitrequest,
    output cache_pkg::way_req_t  o_way_req,
    output cache_pkg::way_mask_t o_way_write,
    output logic                 o_read_miss,
    input  cache_pkg::way_rsp_t  i_rsp [cache_pkg::NUM_WAYS],
    input  cache_pkg::way_idx_t  i_victim,
    output logic                 o_touch,
    output cache_pkg::way_idx_t  o_touch_way,
    output logic                 o_clear,
    output logic [INDEX_W-1:0]   o_clear_index,
    output cache_pkg::mem_req_t  o_mem,
    input  cache_pkg::mem_rsp_t  i_mem
);

    cache_pkg::ctrl_state_t state;
    cache_pkg::p_addr_t     addr_q;
    cache_pkg::byte_en_t    byte_en_q;
    cache_pkg::word_t       wdata_q;
    logic                   is_write_q;
    cache_pkg::way_idx_t    way_q;
    logic                   clearing;
    logic [INDEX_W-1:0]     clear_cnt;

    cache_pkg::way_mask_t   hit_mask;
    cache_pkg::way_idx_t    hit_idx;
    cache_pkg::line_t       hit_line;
    cache_pkg::way_mask_t   target;
    cache_pkg::m_addr_t     fetch_addr;
    logic                   filling;
    logic                   victim_dirty;

    always_comb begin
        hit_mask = '0;
        hit_idx  = '0;
        for (int w = cache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            hit_mask[w] = i_rsp[w].hit;
            if (i_rsp[w].hit) begin
                hit_idx = cache_pkg::way_idx_t'(w);
            end
        end
    end

    assign hit_line     = i_rsp[hit_idx].rdata;
    assign victim_dirty = i_rsp[i_victim].valid && i_rsp[i_victim].dirty;
    assign target       = cache_pkg::way_mask_t'(1) << way_q;
    assign fetch_addr   = {addr_q[cache_pkg::P_ADDR_W-1:2], 3'b000};
    assign filling      = (state == cache_pkg::FETCH_WAIT);

    assign o_p_waitrequest = clearing || (state != cache_pkg::IDLE);
    assign o_read_miss     = ~is_write_q;
    assign o_clear         = clearing;
    assign o_clear_index   = clear_cnt;

    assign o_touch = ((state == cache_pkg::COMP) && |hit_mask) ||
                     (filling && i_mem.readdata_valid);
    assign o_touch_way = (state == cache_pkg::COMP) ? hit_idx : way_q;

    // ******************************
    // Broadcast to the ways
    // ******************************
    always_comb begin
        if (clearing) begin
            o_way_req.addr = cache_pkg::line_addr_t'(clear_cnt);
        end else if (o_p_waitrequest) begin
            o_way_req.addr = addr_q[cache_pkg::P_ADDR_W-1:2];
        end else begin
            o_way_req.addr = i_p_addr[cache_pkg::P_ADDR_W-1:2];   // RAMs ready in COMP.
        end
        o_way_req.wdata   = filling ? i_mem.readdata : {cache_pkg::WORDS_PER_LINE{wdata_q}};
        o_way_req.byte_en = filling ? '1 : byte_en_q;
        o_way_req.word_en = filling ? '1 : cache_pkg::word_en_t'(1) << addr_q[1:0];

        if (filling) begin
            o_way_write = target & {cache_pkg::NUM_WAYS{i_mem.readdata_valid}};
        end else if (state == cache_pkg::HIT_WR || state == cache_pkg::FETCH_MERGE) begin
            o_way_write = target;
        end else begin
            o_way_write = '0;
        end
    end

    // ******************************
    // Request FSM
    // ******************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state              <= cache_pkg::IDLE;
            clearing           <= 1'b1;
            clear_cnt          <= '0;
            o_p_readdata_valid <= 1'b0;
            o_mem.read         <= 1'b0;
            o_mem.write        <= 1'b0;
            is_write_q         <= 1'b0;
            way_q              <= '0;
        end else begin
            o_p_readdata_valid <= 1'b0;
            if (clearing) begin
                clear_cnt <= clear_cnt + 1'b1;
                if (&clear_cnt) begin
                    clearing <= 1'b0;
                end
            end
            case (state)
                cache_pkg::IDLE: begin
                    if (!o_p_waitrequest && (i_p_read || i_p_write)) begin
                        addr_q     <= i_p_addr;
                        byte_en_q  <= i_p_byte_en;
                        wdata_q    <= i_p_writedata;
                        is_write_q <= ~i_p_read;   // Read wins.
                        state      <= cache_pkg::COMP;
                    end
                end
                cache_pkg::COMP: begin
                    if (|hit_mask) begin
                        way_q <= hit_idx;
                        if (is_write_q) begin
                            state <= cache_pkg::HIT_WR;
                        end else begin
                            o_p_readdata       <= hit_line[addr_q[1:0]*cache_pkg::WORD_W +:
                                                           cache_pkg::WORD_W];
                            o_p_readdata_valid <= 1'b1;
                            state              <= cache_pkg::IDLE;
                        end
                    end else begin
                        way_q <= i_victim;
                        if (victim_dirty) begin
                            state <= cache_pkg::WB_LOAD;
                        end else begin
                            o_mem.addr <= fetch_addr;
                            o_mem.read <= 1'b1;
                            state      <= cache_pkg::FETCH_REQ;
                        end
                    end
                end
                cache_pkg::HIT_WR: begin
                    state <= cache_pkg::IDLE;
                end
                cache_pkg::FETCH_REQ: begin
                    if (!i_mem.waitrequest) begin
                        o_mem.read <= 1'b0;
                        state      <= cache_pkg::FETCH_WAIT;
                    end
                end
                cache_pkg::FETCH_WAIT: begin
                    if (i_mem.readdata_valid) begin
                        if (is_write_q) begin
                            state <= cache_pkg::FETCH_MERGE;
                        end else begin
                            // Word straight from the fill.
                            o_p_readdata       <= i_mem.readdata[addr_q[1:0]*cache_pkg::WORD_W +:
                                                                 cache_pkg::WORD_W];
                            o_p_readdata_valid <= 1'b1;
                            state              <= cache_pkg::IDLE;
                        end
                    end
                end
                cache_pkg::FETCH_MERGE: begin
                    state <= cache_pkg::IDLE;
                end
                cache_pkg::WB_LOAD: begin
                    o_mem.addr      <= {i_rsp[way_q].wb_addr, 3'b000};
                    o_mem.writedata <= i_rsp[way_q].rdata;
                    o_mem.write     <= 1'b1;
                    state           <= cache_pkg::WB_REQ;
                end
                cache_pkg::WB_REQ: begin
                    if (!i_mem.waitrequest) begin
                        o_mem.write <= 1'b0;
                        o_mem.addr  <= fetch_addr;
                        o_mem.read  <= 1'b1;
                        state       <= cache_pkg::FETCH_REQ;
                    end
                end
                default: begin
                    state <= cache_pkg::IDLE;
                end
            endcase
        end
    end

    a_mem_rw_excl: assert property (@(posedge clk) disable iff (rst)
        !(o_mem.read && o_mem.write))
        else $error("Memory read and write high together.");

    a_one_hit: assert property (@(posedge clk) disable iff (rst)
        (state == cache_pkg::COMP) |-> $onehot0(hit_mask))
        else $error("More than one way hit.");

endmodule

// ==== cache_pkg.sv ====
package cache_pkg;

    // ******************************
    // Widths
    // ******************************
    localparam int WORD_W         = 32;
    localparam int LINE_W         = 128;
    localparam int WORDS_PER_LINE = 4;
    localparam int NUM_WAYS       = 4;
    localparam int P_ADDR_W       = 25;   // Word address.
    localparam int LINE_ADDR_W    = 23;
    localparam int M_ADDR_W       = 26;   // Line address, three zero bits.

    typedef logic [WORD_W-1:0]         word_t;
    typedef logic [LINE_W-1:0]         line_t;
    typedef logic [P_ADDR_W-1:0]       p_addr_t;
    typedef logic [LINE_ADDR_W-1:0]    line_addr_t;
    typedef logic [M_ADDR_W-1:0]       m_addr_t;
    typedef logic [WORD_W/8-1:0]       byte_en_t;
    typedef logic [WORDS_PER_LINE-1:0] word_en_t;
    typedef logic [NUM_WAYS-1:0]       way_mask_t;
    typedef logic [1:0]                way_idx_t;
    typedef logic [2*NUM_WAYS-1:0]     lru_order_t;   // [1:0] is LRU, [7:6] is MRU.

    typedef enum logic [2:0] {
        IDLE,
        COMP,
        HIT_WR,
        FETCH_REQ,
        FETCH_WAIT,
        FETCH_MERGE,
        WB_LOAD,
        WB_REQ
    } ctrl_state_t;

    // ******************************
    // Bundles
    // ******************************
    typedef struct packed {
        line_addr_t addr;
        line_t      wdata;
        byte_en_t   byte_en;
        word_en_t   word_en;
    } way_req_t;

    typedef struct packed {
        logic       hit;
        logic       valid;
        logic       dirty;
        line_addr_t wb_addr;   // Stored line address.
        line_t      rdata;
    } way_rsp_t;

    typedef struct packed {
        m_addr_t addr;
        line_t   writedata;
        logic    read;
        logic    write;
    } mem_req_t;

    typedef struct packed {
        line_t readdata;
        logic  readdata_valid;
        logic  waitrequest;
    } mem_rsp_t;

endpackage

// ==== cache_stim.txt ====
# name          op  word_addr  byte_en  wdata     exp_rdata  mem_reads  mem_writes
# Hex fields except the two decimal memory counts; exp_rdata is not checked on writes.
miss_rd_w0      rd  0000004    f        00000000  5a5a0004   1          0
hit_rd_w2       rd  0000006    f        00000000  5a5a0006   0          0
hit_wr_part     wr  0000005    5        aabbccdd  00000000   0          0
hit_rd_merge    rd  0000005    f        00000000  5abb00dd   0          0
miss_wr_part    wr  000000b    3        11223344  00000000   1          0
rd_after_wmiss  rd  000000b    f        00000000  5a5a3344   0          0
rd_fill_word    rd  0000008    f        00000000  5a5a0008   0          0
hit_wr_full     wr  000000a    f        0badf00d  00000000   0          0
hit_rd_full     rd  000000a    f        00000000  0badf00d   0          0
lru_fill_a      rd  000000c    f        00000000  5a5a000c   1          0
lru_fill_b      rd  000004c    f        00000000  5a5a004c   1          0
lru_fill_c      rd  000008c    f        00000000  5a5a008c   1          0
lru_fill_d      rd  00000cc    f        00000000  5a5a00cc   1          0
lru_touch_a     rd  000000d    f        00000000  5a5a000d   0          0
lru_fill_e      rd  000010c    f        00000000  5a5a010c   1          0
lru_a_hit       rd  000000e    f        00000000  5a5a000e   0          0
lru_b_miss      rd  000004e    f        00000000  5a5a004e   1          0
lru_c_miss      rd  000008c    f        00000000  5a5a008c   1          0
lru_e_hit       rd  000010d    f        00000000  5a5a010d   0          0
wb_wr_miss      wr  0000015    f        deadbeef  00000000   1          0
wb_fill_1       rd  0000054    f        00000000  5a5a0054   1          0
wb_fill_2       rd  0000094    f        00000000  5a5a0094   1          0
wb_fill_3       rd  00000d4    f        00000000  5a5a00d4   1          0
wb_evict        rd  0000114    f        00000000  5a5a0114   1          1
wb_reread       rd  0000015    f        00000000  deadbeef   1          0
wb_reread_w0    rd  0000014    f        00000000  5a5a0014   0          0
set0_first      rd  0000000    f        00000000  5a5a0000   1          0
set15_first     rd  000003c    f        00000000  5a5a003c   1          0
set8_high_tag   rd  0abcde0    f        00000000  5af1cde0   1          0

// ==== cache_top.sv ====
`timescale 1ns/1ps

module cache_top #(
    parameter int INDEX_W = 14
) (
    input  logic                 clk,
    input  logic                 rst,
    input  cache_pkg::p_addr_t   i_p_addr,
    input  cache_pkg::byte_en_t  i_p_byte_en,
    input  cache_pkg::word_t     i_p_writedata,
    input  logic                 i_p_read,
    input  logic                 i_p_write,
    output cache_pkg::word_t     o_p_readdata,
    output logic                 o_p_readdata_valid,
    output logic                 o_p_waitrequest,
    output cache_pkg::mem_req_t  o_mem,
    input  cache_pkg::mem_rsp_t  i_mem
);

    cache_pkg::way_req_t  way_req;
    cache_pkg::way_rsp_t  way_rsp [cache_pkg::NUM_WAYS];
    cache_pkg::way_mask_t way_write;
    cache_pkg::way_mask_t valid_mask;
    cache_pkg::way_idx_t  victim;
    cache_pkg::way_idx_t  touch_way;
    logic                 read_miss;
    logic                 touch;
    logic                 clear;
    logic [INDEX_W-1:0]   clear_index;

    // ******************************
    // Ways
    // ******************************
    for (genvar g = 0; g < cache_pkg::NUM_WAYS; g++) begin : g_way
        cache_way #(.INDEX_W(INDEX_W)) way_i (
            .clk           (clk),
            .rst           (rst),
            .i_clear_index (clear_index),
            .i_clear       (clear),
            .i_req         (way_req),
            .i_write       (way_write[g]),
            .i_read_miss   (read_miss),
            .o_rsp         (way_rsp[g])
        );
        assign valid_mask[g] = way_rsp[g].valid;
    end

    lru_table #(.INDEX_W(INDEX_W)) lru_i (
        .clk         (clk),
        .i_index     (way_req.addr[INDEX_W-1:0]),
        .i_clear     (clear),
        .i_touch     (touch),
        .i_touch_way (touch_way),
        .i_valid     (valid_mask),
        .o_victim    (victim)
    );

    cache_ctrl #(.INDEX_W(INDEX_W)) ctrl_i (
        .clk                (clk),
        .rst                (rst),
        .i_p_addr           (i_p_addr),
        .i_p_byte_en        (i_p_byte_en),
        .i_p_writedata      (i_p_writedata),
        .i_p_read           (i_p_read),
        .i_p_write          (i_p_write),
        .o_p_readdata       (o_p_readdata),
        .o_p_readdata_valid (o_p_readdata_valid),
        .o_p_waitrequest    (o_p_waitrequest),
        .o_way_req          (way_req),
        .o_way_write        (way_write),
        .o_read_miss        (read_miss),
        .i_rsp              (way_rsp),
        .i_victim           (victim),
        .o_touch            (touch),
        .o_touch_way        (touch_way),
        .o_clear            (clear),
        .o_clear_index      (clear_index),
        .o_mem              (o_mem),
        .i_mem              (i_mem)
    );

endmodule

// ==== cache_way.sv ====
`timescale 1ns/1ps

module cache_way #(
    parameter int INDEX_W = 14
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [INDEX_W-1:0]   i_clear_index,
    input  logic                 i_clear,
    input  cache_pkg::way_req_t  i_req,
    input  logic                 i_write,
    input  logic                 i_read_miss,
    output cache_pkg::way_rsp_t  o_rsp
);

    localparam int TAG_W   = cache_pkg::LINE_ADDR_W - INDEX_W;
    localparam int DEPTH   = 2 ** INDEX_W;
    localparam int BYTES_W = cache_pkg::WORD_W / 8;

    cache_pkg::line_t      data_mem [DEPTH];
    logic [TAG_W+1:0]      tag_mem  [DEPTH];   // {dirty, valid, tag}.

    logic [INDEX_W-1:0]    index;
    logic [TAG_W-1:0]      req_tag;
    cache_pkg::line_addr_t addr_q;
    cache_pkg::line_t      rdata_q;
    logic [TAG_W+1:0]      entry_q;
    logic [TAG_W-1:0]      stored_tag;
    logic                  stored_valid;
    logic                  stored_dirty;

    assign index   = i_req.addr[INDEX_W-1:0];
    assign req_tag = addr_q[cache_pkg::LINE_ADDR_W-1:INDEX_W];

    assign {stored_dirty, stored_valid, stored_tag} = entry_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_q <= '0;
        end else begin
            addr_q <= i_req.addr;
        end
    end

    // ******************************
    // Line array, byte writable
    // ******************************
    always_ff @(posedge clk) begin
        for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
            for (int b = 0; b < BYTES_W; b++) begin
                if (i_write && i_req.word_en[w] && i_req.byte_en[b]) begin
                    data_mem[index][(w*BYTES_W+b)*8 +: 8] <= i_req.wdata[(w*BYTES_W+b)*8 +: 8];
                end
            end
        end
        rdata_q <= data_mem[index];
    end

    // ******************************
    // Tag array
    // ******************************
    always_ff @(posedge clk) begin
        if (i_clear) begin
            tag_mem[i_clear_index] <= '0;   // Sweep invalidates.
        end else if (i_write) begin
            tag_mem[index] <= {~i_read_miss, 1'b1, req_tag};   // A hit rewrites the same tag.
        end
        entry_q <= tag_mem[index];
    end

    always_comb begin
        o_rsp.hit     = stored_valid && (stored_tag == req_tag);
        o_rsp.valid   = stored_valid;
        o_rsp.dirty   = stored_dirty;
        o_rsp.wb_addr = {stored_tag, addr_q[INDEX_W-1:0]};
        o_rsp.rdata   = rdata_q;
    end

endmodule

// ==== files.f ====
cache_pkg.sv
cache_way.sv
lru_table.sv
cache_ctrl.sv
cache_top.sv
tb_mem_model.sv
tb_cache.sv

// ==== lru_table.sv ====
`timescale 1ns/1ps

module lru_table #(
    parameter int INDEX_W = 14
) (
    input  logic                  clk,
    input  logic [INDEX_W-1:0]    i_index,
    input  logic                  i_clear,
    input  logic                  i_touch,
    input  cache_pkg::way_idx_t   i_touch_way,
    input  cache_pkg::way_mask_t  i_valid,
    output cache_pkg::way_idx_t   o_victim
);

    localparam cache_pkg::lru_order_t IDENT = 8'b11_10_01_00;

    cache_pkg::lru_order_t order_mem [2**INDEX_W];
    cache_pkg::lru_order_t order_q;
    cache_pkg::lru_order_t order_upd;
    cache_pkg::way_mask_t  seen;

    always_ff @(posedge clk) begin
        if (i_clear) begin
            order_mem[i_index] <= IDENT;
        end else if (i_touch) begin
            order_mem[i_index] <= order_upd;
        end
        order_q <= order_mem[i_index];
    end

    // Lowest invalid way first, else the LRU slot.
    always_comb begin
        o_victim = order_q[1:0];
        for (int j = cache_pkg::NUM_WAYS - 1; j >= 0; j--) begin
            if (!i_valid[j]) begin
                o_victim = cache_pkg::way_idx_t'(j);
            end
        end
    end

    // ******************************
    // Move touched way to MRU
    // ******************************
    always_comb begin
        logic found;
        found     = 1'b0;
        order_upd = order_q;
        for (int j = 0; j < cache_pkg::NUM_WAYS - 1; j++) begin
            if (order_q[2*j +: 2] == i_touch_way) begin
                found = 1'b1;
            end
            // Entries above the touched one slide down.
            order_upd[2*j +: 2] = found ? order_q[2*j+2 +: 2] : order_q[2*j +: 2];
        end
        order_upd[7:6] = i_touch_way;
    end

    always_comb begin
        seen = '0;
        for (int j = 0; j < cache_pkg::NUM_WAYS; j++) begin
            seen[order_q[2*j +: 2]] = 1'b1;
        end
    end

    a_order_perm: assert property (@(posedge clk) i_touch |-> &seen)
        else $error("LRU order is not a permutation.");

endmodule

// ==== tb_cache.sv ====
`timescale 1ns/1ps

module tb_cache;

    localparam int INDEX_W         = 4;
    localparam int SEED            = 38020;
    localparam int RESET_CYCLES    = 2;
    localparam int SWEEP_CYCLES    = 2 ** INDEX_W;
    localparam int CYCLES_PER_TEST = 60;

    typedef struct {
        string               name;
        bit                  is_write;
        cache_pkg::p_addr_t  addr;
        cache_pkg::byte_en_t byte_en;
        cache_pkg::word_t    wdata;
        cache_pkg::word_t    exp_rdata;
        int                  exp_reads;
        int                  exp_writes;
    } stim_t;

    logic                clk;
    logic                rst;
    cache_pkg::p_addr_t  p_addr;
    cache_pkg::byte_en_t p_byte_en;
    cache_pkg::word_t    p_writedata;
    logic                p_read;
    logic                p_write;
    cache_pkg::word_t    p_readdata;
    logic                p_readdata_valid;
    logic                p_waitrequest;
    cache_pkg::mem_req_t mem_req;
    cache_pkg::mem_rsp_t mem_rsp;

    stim_t tests [$];
    int    errors      = 0;
    int    passed      = 0;
    int    mem_reads   = 0;
    int    mem_writes  = 0;
    int    cycle_cnt   = 0;
    int    cycle_limit = RESET_CYCLES + SWEEP_CYCLES + CYCLES_PER_TEST;

    cache_top #(.INDEX_W(INDEX_W)) dut_i (
        .clk                (clk),
        .rst                (rst),
        .i_p_addr           (p_addr),
        .i_p_byte_en        (p_byte_en),
        .i_p_writedata      (p_writedata),
        .i_p_read           (p_read),
        .i_p_write          (p_write),
        .o_p_readdata       (p_readdata),
        .o_p_readdata_valid (p_readdata_valid),
        .o_p_waitrequest    (p_waitrequest),
        .o_mem              (mem_req),
        .i_mem              (mem_rsp)
    );

    tb_mem_model #(.SEED(SEED)) mem_i (
        .clk   (clk),
        .rst   (rst),
        .i_req (mem_req),
        .o_rsp (mem_rsp)
    );

    always #4 clk = ~clk;

    // Strobe state is stable mid-cycle and is taken at the next edge.
    always @(negedge clk) begin
        if (!rst) begin
            if (mem_req.read && !mem_rsp.waitrequest) begin
                mem_reads++;
            end
            if (mem_req.write && !mem_rsp.waitrequest) begin
                mem_writes++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped answering", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check_value(input string test_name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    // ******************************
    // Stimulus file
    // ******************************
    task automatic load_stimulus();
        int          fd;
        int          n;
        int          line_no;
        string       line;
        string       name;
        string       op;
        logic [31:0] addr;
        logic [31:0] byte_en;
        logic [31:0] wdata;
        logic [31:0] exp_rdata;
        int          exp_reads;
        int          exp_writes;
        stim_t       s;
        line_no = 0;
        fd = $fopen("cache_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the stimulus file cache_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                line_no++;
                if (line.len() > 0 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%s %s %h %h %h %h %d %d", name, op, addr, byte_en,
                                wdata, exp_rdata, exp_reads, exp_writes);
                    if (n == 8 && (op == "rd" || op == "wr")) begin
                        s.name       = name;
                        s.is_write   = (op == "wr");
                        s.addr       = cache_pkg::p_addr_t'(addr);
                        s.byte_en    = cache_pkg::byte_en_t'(byte_en);
                        s.wdata      = wdata;
                        s.exp_rdata  = exp_rdata;
                        s.exp_reads  = exp_reads;
                        s.exp_writes = exp_writes;
                        tests.push_back(s);
                    end else if (n > 0) begin
                        errors++;
                        $display("stimulus line %0d could not be parsed", line_no);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ******************************
    // One processor request
    // ******************************
    task automatic run_request(input stim_t t);
        int reads_start;
        int writes_start;
        int errors_start;
        reads_start  = mem_reads;
        writes_start = mem_writes;
        errors_start = errors;
        @(posedge clk);
        #1;
        p_addr      = t.addr;
        p_byte_en   = t.byte_en;
        p_writedata = t.wdata;
        p_read      = !t.is_write;
        p_write     = t.is_write;
        @(negedge clk);
        while (p_waitrequest) begin
            @(negedge clk);
        end
        @(posedge clk);   // Accepted here.
        #1;
        p_read  = 1'b0;
        p_write = 1'b0;
        @(negedge clk);
        if (t.is_write) begin
            while (p_waitrequest) begin
                @(negedge clk);
            end
        end else begin
            while (!p_readdata_valid) begin
                @(negedge clk);
            end
            check_value(t.name, "read data", t.exp_rdata, p_readdata);
        end
        check_value(t.name, "memory reads", t.exp_reads, mem_reads - reads_start);
        check_value(t.name, "memory writes", t.exp_writes, mem_writes - writes_start);
        if (errors == errors_start) begin
            passed++;
            $display("test %s ok", t.name);
        end else begin
            $display("test %s failed", t.name);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        p_addr      = '0;
        p_byte_en   = '0;
        p_writedata = '0;
        p_read      = 1'b0;
        p_write     = 1'b0;
        load_stimulus();
        cycle_limit = tests.size() * CYCLES_PER_TEST + SWEEP_CYCLES + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (tests[i]) begin
            run_request(tests[i]);
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests.size(), passed, tests.size() - passed, errors);
        if (errors == 0 && tests.size() > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model #(
    parameter int SEED = 1
) (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::mem_req_t i_req,
    output cache_pkg::mem_rsp_t o_rsp
);

    cache_pkg::line_t      mem [cache_pkg::line_addr_t];   // Lines written back.
    cache_pkg::line_addr_t req_line;
    cache_pkg::line_addr_t rd_line;
    cache_pkg::line_t      rdata;
    logic [1:0]            wait_cnt;
    logic                  rd_pend;
    logic                  rvalid;

    // Word w of line L starts as (L*4 + w) ^ 5A5A0000.
    function automatic cache_pkg::line_t line_value(cache_pkg::line_addr_t line);
        cache_pkg::line_t l;
        if (mem.exists(line)) begin
            l = mem[line];
        end else begin
            for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
                l[w*32 +: 32] = (32'(line) * 4 + w) ^ 32'h5A5A_0000;
            end
        end
        return l;
    endfunction

    assign req_line = i_req.addr[cache_pkg::M_ADDR_W-1:3];

    always_comb begin
        o_rsp.readdata       = rdata;
        o_rsp.readdata_valid = rvalid;
        o_rsp.waitrequest    = (i_req.read || i_req.write) && (wait_cnt != 2'd0);
    end

    initial begin
        void'($urandom(SEED));   // One seed for all wait draws.
        wait_cnt <= 2'd0;
        rd_pend  <= 1'b0;
        rvalid   <= 1'b0;
        rdata    <= '0;
        rd_line  <= '0;
        forever begin
            @(posedge clk);
            if (rst) begin
                wait_cnt <= 2'($urandom % 4);
                rd_pend  <= 1'b0;
                rvalid   <= 1'b0;
            end else begin
                rvalid  <= rd_pend;   // Valid two edges after accept.
                rd_pend <= 1'b0;
                if (rd_pend) begin
                    rdata <= line_value(rd_line);
                end
                if (i_req.read || i_req.write) begin
                    if (wait_cnt != 2'd0) begin
                        wait_cnt <= wait_cnt - 2'd1;
                    end else begin
                        wait_cnt <= 2'($urandom % 4);   // Stall for the next access.
                        if (i_req.read) begin
                            rd_pend <= 1'b1;
                            rd_line <= req_line;
                        end else begin
                            mem[req_line] = i_req.writedata;
                        end
                    end
                end
            end
        end
    end

endmodule
